// ==== sources.f ====
+incdir+sim
design/mem3r1w_pkg.sv
design/sram_bank.sv
design/mem_copy.sv
design/ecc_read_port.sv
design/mem_cmd_stage.sv
design/mem3r1w_top.sv
sim/tb_mem3r1w.sv

// ==== Bender.yml ====
package:
  name: mem3r1w

sources:
  - target: any(rtl, simulation)
    files:
      - design/mem3r1w_pkg.sv
      - design/sram_bank.sv
      - design/mem_copy.sv
      - design/ecc_read_port.sv
      - design/mem_cmd_stage.sv
      - design/mem3r1w_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mem3r1w.sv

// ==== sim/tb_mem3r1w_model.svh ====
`ifndef TB_MEM3R1W_MODEL_SVH
`define TB_MEM3R1W_MODEL_SVH

typedef struct packed {
  logic [31:0]                    due;  // step on which vld must show
  logic [mem3r1w_pkg::data_w-1:0] dout;
  logic                           serr;
  logic                           derr;
  logic [mem3r1w_pkg::padr_w-1:0] padr;
} exp_rsp_t;

logic [mem3r1w_pkg::data_w-1:0] model_data [1 << mem3r1w_pkg::addr_w];
logic [1:0]                     model_flip [1 << mem3r1w_pkg::addr_w];

exp_rsp_t exp_q [mem3r1w_pkg::num_rdpt][$];

// init sweep leaves clean zero words everywhere
function automatic void model_clear();
  for (int a = 0; a < (1 << mem3r1w_pkg::addr_w); a++) begin
    model_data[a] = '0;
    model_flip[a] = 2'b00;
  end
endfunction

function automatic void model_write(input logic [mem3r1w_pkg::addr_w-1:0] adr,
                                    input logic [mem3r1w_pkg::data_w-1:0] din,
                                    input logic [1:0]                     flip);
  model_data[adr] = din;
  model_flip[adr] = flip;
endfunction

// sampled on the next edge, response visible three steps after the drive
function automatic void expect_read(input int                            port,
                                    input logic [mem3r1w_pkg::addr_w-1:0] adr);
  exp_rsp_t e;
  e.due  = cyc + 3;
  e.dout = model_data[adr];  // flips only hit check bits 0 and 1, data survives
  e.serr = (model_flip[adr] == 2'b01) || (model_flip[adr] == 2'b10);
  e.derr = (model_flip[adr] == 2'b11);
  e.padr = {mem3r1w_pkg::copy_w'(port), adr};  // adr is already bank then row
  exp_q[port].push_back(e);
endfunction

function automatic int pending();
  int n;
  n = 0;
  for (int p = 0; p < mem3r1w_pkg::num_rdpt; p++) n += exp_q[p].size();
  return n;
endfunction

task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    errors++;
    $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
  end
endtask

task automatic check_outputs();
  exp_rsp_t e;
  for (int p = 0; p < mem3r1w_pkg::num_rdpt; p++) begin
    if (exp_q[p].size() > 0 && exp_q[p][0].due == cyc) begin
      e = exp_q[p].pop_front();
      check_val($sformatf("port %0d vld", p), rsp[p].vld, 1'b1);
      check_val($sformatf("port %0d dout", p), rsp[p].dout, e.dout);
      check_val($sformatf("port %0d serr", p), rsp[p].serr, e.serr);
      check_val($sformatf("port %0d derr", p), rsp[p].derr, e.derr);
      check_val($sformatf("port %0d padr", p), rsp[p].padr, e.padr);
    end else begin
      check_val($sformatf("port %0d vld with no read outstanding", p), rsp[p].vld, 1'b0);
    end
  end
endtask

`endif

// ==== sim/tb_mem3r1w.sv ====
`timescale 1ns/100ps

module tb_mem3r1w;

  typedef mem3r1w_pkg::rd_cmd_t [mem3r1w_pkg::num_rdpt-1:0] rd_vec_t;

  logic                 clk;
  logic                 rst_n;
  mem3r1w_pkg::wr_cmd_t wr;
  mem3r1w_pkg::rd_cmd_t rd  [mem3r1w_pkg::num_rdpt];
  mem3r1w_pkg::rd_rsp_t rsp [mem3r1w_pkg::num_rdpt];
  logic                 ready;

  int cyc;
  int errors;
  int test_num;
  int tests_failed;
  int test_err0;

  `include "tb_mem3r1w_model.svh"

  mem3r1w_top uut (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .rsp   (rsp),
    .ready (ready)
  );

  always #5 clk = ~clk;

  function automatic logic [mem3r1w_pkg::addr_w-1:0] rand_adr();
    if ($urandom_range(3) == 0) return mem3r1w_pkg::addr_w'($urandom);
    return {2'($urandom), 5'b00000, 3'($urandom)};  // small hot set in every bank
  endfunction

  function automatic mem3r1w_pkg::wr_cmd_t wr_cmd(input logic [mem3r1w_pkg::addr_w-1:0] adr,
                                                  input logic [mem3r1w_pkg::data_w-1:0] din,
                                                  input logic [1:0]                     flip);
    return '{vld: 1'b1, adr: adr, din: din, flip: flip};
  endfunction

  function automatic rd_vec_t rand_reads();
    rd_vec_t r;
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) begin
      r[i].vld = 1'b1;
      r[i].adr = rand_adr();
    end
    return r;
  endfunction

  function automatic rd_vec_t all_reads(input logic [mem3r1w_pkg::addr_w-1:0] adr);
    rd_vec_t r;
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) r[i] = '{vld: 1'b1, adr: adr};
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
    cyc++;
    check_outputs();
  endtask

  // reads see the model before this cycle's write
  task automatic issue(input mem3r1w_pkg::wr_cmd_t w, input rd_vec_t r);
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) begin
      rd[i] = r[i];
      if (ready === 1'b1 && r[i].vld) expect_read(i, r[i].adr);
    end
    wr = w;
    if (ready === 1'b1 && w.vld) model_write(w.adr, w.din, w.flip);
  endtask

  task automatic finish_run();
    $display("tests run %0d, tests failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic timed_out(input string msg);
    errors++;
    $display("timeout at %0d ns: %s", $time, msg);
    finish_run();
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors != test_err0) tests_failed++;
    $display("test %0d %s: %s, %0d errors", test_num, name,
             (errors == test_err0) ? "passed" : "failed", errors - test_err0);
    test_err0 = errors;
  endtask

  task automatic apply_reset();
    issue('0, '0);
    rst_n = 1'b0;
    repeat (5) step();
    check_val("ready during reset", ready, 1'b0);
    rst_n = 1'b1;
    model_clear();
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (ready !== 1'b1 && n < limit) begin
      step();
      n++;
    end
    if (ready !== 1'b1) timed_out($sformatf("ready still low %0d cycles after reset", limit));
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    issue('0, '0);
    while (pending() > 0 && n < limit) begin
      step();
      n++;
    end
    if (pending() > 0) timed_out("read responses still missing after the last read");
    repeat (2) step();  // catch stray vld pulses
  endtask

  initial begin
    mem3r1w_pkg::wr_cmd_t          w;
    logic [mem3r1w_pkg::addr_w-1:0] a;
    logic [mem3r1w_pkg::addr_w-1:0] b;
    logic [mem3r1w_pkg::data_w-1:0] d0;
    int                             n;
    clk          = 1'b0;
    rst_n        = 1'b0;
    wr           = '0;
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) rd[i] = '0;
    cyc          = 0;
    errors       = 0;
    test_num     = 0;
    tests_failed = 0;
    test_err0    = 0;
    void'($urandom(32'hadf7834e));

    apply_reset();
    wait_ready(mem3r1w_pkg::num_row + 20);
    repeat (16) begin
      issue('0, rand_reads());
      step();
    end
    drain(10);
    end_test("init sweep reads zero");

    for (int k = 0; k < 300; k++) begin
      w = ($urandom_range(3) != 0) ? wr_cmd(rand_adr(), $urandom, 2'b00) : '0;
      issue(w, rand_reads());
      step();
    end
    drain(10);
    end_test("random writes and reads");

    a  = rand_adr();
    d0 = $urandom;
    issue(wr_cmd(a, d0, 2'b00), '0);
    step();
    issue(wr_cmd(a, ~d0, 2'b00), all_reads(a));  // same cycle gives the old word
    step();
    issue('0, all_reads(a));
    step();
    drain(10);
    end_test("write then read collision");

    a = rand_adr();
    b = a ^ 10'h155;
    issue(wr_cmd(a, $urandom, 2'b01), '0);
    step();
    issue(wr_cmd(b, $urandom, 2'b10), all_reads(a));
    step();
    issue(wr_cmd(a, $urandom, 2'b00), all_reads(b));
    step();
    issue('0, all_reads(a));
    step();
    drain(10);
    end_test("single bit flip corrected");

    a = rand_adr();
    issue(wr_cmd(a, $urandom, 2'b11), '0);
    step();
    issue('0, all_reads(a));
    step();
    drain(10);
    end_test("double bit flip detected");

    apply_reset();
    n = 0;
    while (ready !== 1'b1 && n < mem3r1w_pkg::num_row + 20) begin
      issue(wr_cmd(rand_adr(), $urandom, 2'($urandom)), rand_reads());
      step();
      n++;
    end
    if (ready !== 1'b1) timed_out("ready still low during the second init sweep");
    issue('0, '0);
    repeat (16) begin
      issue('0, rand_reads());
      step();
    end
    drain(10);
    end_test("commands ignored while not ready");

    finish_run();
  end

endmodule

// ==== design/mem3r1w_top.sv ====
`timescale 1ns/100ps

module mem3r1w_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mem3r1w_pkg::wr_cmd_t wr,
  input  mem3r1w_pkg::rd_cmd_t rd  [mem3r1w_pkg::num_rdpt],
  output mem3r1w_pkg::rd_rsp_t rsp [mem3r1w_pkg::num_rdpt],
  output logic                 ready
);

  mem3r1w_pkg::mem_wr_t mem_wr;
  mem3r1w_pkg::mem_rd_t mem_rd [mem3r1w_pkg::num_rdpt];

  logic [mem3r1w_pkg::code_w-1:0] code    [mem3r1w_pkg::num_rdpt];
  logic                           rd_en   [mem3r1w_pkg::num_rdpt];
  logic [mem3r1w_pkg::bank_w-1:0] rd_bank [mem3r1w_pkg::num_rdpt];
  logic [mem3r1w_pkg::row_w-1:0]  rd_row  [mem3r1w_pkg::num_rdpt];

  mem_cmd_stage u_cmd (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (wr),
    .rd     (rd),
    .ready  (ready),
    .mem_wr (mem_wr),
    .mem_rd (mem_rd)
  );

  // one copy per read port, every copy sees every write
  for (genvar i = 0; i < mem3r1w_pkg::num_rdpt; i++) begin : g_port
    mem_copy u_copy (
      .clk     (clk),
      .rst_n   (rst_n),
      .mem_wr  (mem_wr),
      .mem_rd  (mem_rd[i]),
      .code    (code[i]),
      .rd_en   (rd_en[i]),
      .rd_bank (rd_bank[i]),
      .rd_row  (rd_row[i])
    );

    ecc_read_port #(
      .copy_id (mem3r1w_pkg::copy_w'(i))
    ) u_ecc (
      .clk     (clk),
      .rst_n   (rst_n),
      .code    (code[i]),
      .rd_en   (rd_en[i]),
      .rd_bank (rd_bank[i]),
      .rd_row  (rd_row[i]),
      .rsp     (rsp[i])
    );
  end

endmodule

// ==== design/mem_cmd_stage.sv ====
`timescale 1ns/100ps

module mem_cmd_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mem3r1w_pkg::wr_cmd_t wr,
  input  mem3r1w_pkg::rd_cmd_t rd     [mem3r1w_pkg::num_rdpt],
  output logic                 ready,
  output mem3r1w_pkg::mem_wr_t mem_wr,
  output mem3r1w_pkg::mem_rd_t mem_rd [mem3r1w_pkg::num_rdpt]
);

  logic [1:0] rst_sync;
  logic       rst_int_n;

  logic [mem3r1w_pkg::row_w-1:0] init_row;

  logic                           wr_en_q;
  logic                           wr_bcast_q;
  logic [mem3r1w_pkg::bank_w-1:0] wr_bank_q;
  logic [mem3r1w_pkg::row_w-1:0]  wr_row_q;
  logic [mem3r1w_pkg::code_w-1:0] wr_code_q;

  logic [mem3r1w_pkg::num_rdpt-1:0] rd_en_q;
  logic [mem3r1w_pkg::bank_w-1:0]   rd_bank_q [mem3r1w_pkg::num_rdpt];
  logic [mem3r1w_pkg::row_w-1:0]    rd_row_q  [mem3r1w_pkg::num_rdpt];

  // assert asynchronously, release on the second edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end
  assign rst_int_n = rst_sync[1];

  always_ff @(posedge clk or negedge rst_int_n) begin
    if (!rst_int_n) begin
      ready      <= 1'b0;
      init_row   <= '0;
      wr_en_q    <= 1'b0;
      wr_bcast_q <= 1'b0;
      rd_en_q    <= '0;
    end else if (!ready) begin  // init sweep, one row per cycle
      init_row   <= init_row + 1'b1;
      wr_en_q    <= 1'b1;
      wr_bcast_q <= 1'b1;
      rd_en_q    <= '0;
      if (init_row == mem3r1w_pkg::row_w'(mem3r1w_pkg::num_row - 1)) ready <= 1'b1;
    end else begin
      wr_en_q    <= wr.vld;
      wr_bcast_q <= 1'b0;
      for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) rd_en_q[i] <= rd[i].vld;
    end
  end

  always_ff @(posedge clk) begin
    if (ready) begin
      wr_bank_q <= wr.adr[mem3r1w_pkg::addr_w-1 -: mem3r1w_pkg::bank_w];
      wr_row_q  <= wr.adr[mem3r1w_pkg::row_w-1:0];
      wr_code_q <= mem3r1w_pkg::secded_encode(wr.din) ^
                   {{(mem3r1w_pkg::code_w-2){1'b0}}, wr.flip};
    end else begin
      wr_bank_q <= '0;
      wr_row_q  <= init_row;
      wr_code_q <= '0;  // all-zero is a valid code word
    end
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) begin
      rd_bank_q[i] <= rd[i].adr[mem3r1w_pkg::addr_w-1 -: mem3r1w_pkg::bank_w];
      rd_row_q[i]  <= rd[i].adr[mem3r1w_pkg::row_w-1:0];
    end
  end

  assign mem_wr = '{en: wr_en_q, bcast: wr_bcast_q, bank: wr_bank_q,
                    row: wr_row_q, code: wr_code_q};

  always_comb begin
    for (int i = 0; i < mem3r1w_pkg::num_rdpt; i++) begin
      mem_rd[i] = '{en: rd_en_q[i], bank: rd_bank_q[i], row: rd_row_q[i]};
    end
  end

  // a user write offered during init never reaches the banks
  a_no_user_wr_in_init: assert property (
    @(posedge clk) disable iff (!rst_int_n)
    (!ready && wr.vld) |=> (!mem_wr.en || mem_wr.bcast)
  );

endmodule

// ==== design/ecc_read_port.sv ====
`timescale 1ns/100ps

module ecc_read_port #(
  parameter logic [mem3r1w_pkg::copy_w-1:0] copy_id = '0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [mem3r1w_pkg::code_w-1:0] code,
  input  logic                           rd_en,
  input  logic [mem3r1w_pkg::bank_w-1:0] rd_bank,
  input  logic [mem3r1w_pkg::row_w-1:0]  rd_row,
  output mem3r1w_pkg::rd_rsp_t           rsp
);

  logic [mem3r1w_pkg::chk_w-2:0]  syn;
  logic                           par_err;  // odd overall parity
  logic [mem3r1w_pkg::code_w-1:0] fixed;
  logic [mem3r1w_pkg::data_w-1:0] data;
  logic                           serr;
  logic                           derr;

  logic                           vld_q;
  logic [mem3r1w_pkg::data_w-1:0] dout_q;
  logic                           serr_q;
  logic                           derr_q;
  logic [mem3r1w_pkg::padr_w-1:0] padr_q;

  always_comb begin
    syn = '0;
    for (int p = 1; p < mem3r1w_pkg::code_w; p++) begin
      for (int k = 0; k < mem3r1w_pkg::chk_w - 1; k++) begin
        if (p[k]) syn[k] = syn[k] ^ code[p-1];
      end
    end
    par_err = ^code;
  end

  always_comb begin
    fixed = code;
    serr  = 1'b0;
    derr  = 1'b0;
    if (par_err) begin
      if (syn == '0) begin
        fixed[mem3r1w_pkg::code_w-1] = ~code[mem3r1w_pkg::code_w-1];  // parity bit itself
        serr = 1'b1;
      end else if (int'(syn) < mem3r1w_pkg::code_w) begin
        fixed[int'(syn)-1] = ~code[int'(syn)-1];
        serr = 1'b1;
      end else begin
        derr = 1'b1;  // syndrome points past the word
      end
    end else if (syn != '0) begin
      derr = 1'b1;
    end
  end

  // data bits sit at the non power of two positions
  always_comb begin
    int d;
    d    = 0;
    data = '0;
    for (int p = 1; p < mem3r1w_pkg::code_w; p++) begin
      if ((p & (p - 1)) != 0) begin
        data[d] = fixed[p-1];
        d++;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    dout_q <= data;
    serr_q <= serr;
    derr_q <= derr;
    padr_q <= {copy_id, rd_bank, rd_row};
  end

  assign rsp = '{vld: vld_q, dout: dout_q, serr: serr_q, derr: derr_q, padr: padr_q};

  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    rsp.vld |-> !(rsp.serr && rsp.derr)
  );

endmodule

// ==== design/mem_copy.sv ====
`timescale 1ns/100ps

module mem_copy (
  input  logic                           clk,
  input  logic                           rst_n,
  input  mem3r1w_pkg::mem_wr_t           mem_wr,
  input  mem3r1w_pkg::mem_rd_t           mem_rd,
  output logic [mem3r1w_pkg::code_w-1:0] code,
  output logic                           rd_en,
  output logic [mem3r1w_pkg::bank_w-1:0] rd_bank,
  output logic [mem3r1w_pkg::row_w-1:0]  rd_row
);

  logic [mem3r1w_pkg::num_bank-1:0] we;
  logic [mem3r1w_pkg::num_bank-1:0] re;
  logic [mem3r1w_pkg::code_w-1:0]   bank_dout [mem3r1w_pkg::num_bank];

  always_comb begin
    for (int b = 0; b < mem3r1w_pkg::num_bank; b++) begin
      we[b] = mem_wr.en && (mem_wr.bcast || (mem_wr.bank == mem3r1w_pkg::bank_w'(b)));
      re[b] = mem_rd.en && (mem_rd.bank == mem3r1w_pkg::bank_w'(b));
    end
  end

  for (genvar b = 0; b < mem3r1w_pkg::num_bank; b++) begin : g_bank
    sram_bank u_bank (
      .clk   (clk),
      .we    (we[b]),
      .wrow  (mem_wr.row),
      .wdata (mem_wr.code),
      .re    (re[b]),
      .rrow  (mem_rd.row),
      .rdata (bank_dout[b])
    );
  end

  // track the bank read so the mux lines up with rdata
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en <= 1'b0;
    end else begin
      rd_en <= mem_rd.en;
    end
  end

  always_ff @(posedge clk) begin
    rd_bank <= mem_rd.bank;
    rd_row  <= mem_rd.row;
  end

  assign code = bank_dout[rd_bank];

  a_one_bank_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_rd.en |-> $onehot(re)
  );

endmodule

// ==== design/sram_bank.sv ====
`timescale 1ns/100ps

module sram_bank (
  input  logic                           clk,
  input  logic                           we,
  input  logic [mem3r1w_pkg::row_w-1:0]  wrow,
  input  logic [mem3r1w_pkg::code_w-1:0] wdata,
  input  logic                           re,
  input  logic [mem3r1w_pkg::row_w-1:0]  rrow,
  output logic [mem3r1w_pkg::code_w-1:0] rdata
);

  logic [mem3r1w_pkg::code_w-1:0] mem [mem3r1w_pkg::num_row];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wrow] <= wdata;
    end
  end

  // same-row collision returns the old word
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[rrow];
    end
  end

endmodule

// ==== design/mem3r1w_pkg.sv ====
package mem3r1w_pkg;

  localparam int data_w   = 32;
  localparam int chk_w    = 7;
  localparam int code_w   = data_w + chk_w;
  localparam int addr_w   = 10;
  localparam int num_bank = 4;
  localparam int bank_w   = 2;
  localparam int num_row  = 256;
  localparam int row_w    = 8;
  localparam int num_rdpt = 3;
  localparam int copy_w   = 2;
  localparam int padr_w   = copy_w + bank_w + row_w;

  typedef struct packed {
    logic              vld;
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] din;
    logic [1:0]        flip;  // corrupts code bits 1:0 when written
  } wr_cmd_t;

  typedef struct packed {
    logic              vld;
    logic [addr_w-1:0] adr;
  } rd_cmd_t;

  // bcast writes the row in every bank of a copy, used by the init sweep
  typedef struct packed {
    logic              en;
    logic              bcast;
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
    logic [code_w-1:0] code;
  } mem_wr_t;

  typedef struct packed {
    logic              en;
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
  } mem_rd_t;

  typedef struct packed {
    logic              vld;
    logic [data_w-1:0] dout;
    logic              serr;
    logic              derr;
    logic [padr_w-1:0] padr;  // copy, bank, row
  } rd_rsp_t;

  // hamming positions 1..38 in code[37:0], check bits at powers of two,
  // overall parity on top
  function automatic logic [code_w-1:0] secded_encode(input logic [data_w-1:0] data);
    logic [code_w-1:0] c;
    int                d;
    c = '0;
    d = 0;
    for (int p = 1; p < code_w; p++) begin
      if ((p & (p - 1)) != 0) begin
        c[p-1] = data[d];
        d++;
      end
    end
    for (int k = 0; k < chk_w - 1; k++) begin
      for (int p = 1; p < code_w; p++) begin
        if (p[k] && ((p & (p - 1)) != 0)) c[(1 << k) - 1] = c[(1 << k) - 1] ^ c[p-1];
      end
    end
    c[code_w-1] = ^c[code_w-2:0];
    return c;
  endfunction

endpackage
